// ==== sources.f ====
hw/core_regs_pkg.sv
hw/reg_bus_if.sv
hw/reg_decoder.sv
hw/device_id_regs.sv
hw/reprog_ctrl.sv
hw/cpci_core_top.sv
verification/cpci_core_sva.sv
verification/tb_cpci_core.sv

// ==== verification/tb_cpci_core.sv ====
//----------------------------------------------------------------------
// Testbench for cpci_core_top with a model of the configuration device.
// The model runs cclk at 10 core cycles and raises init_b on a cclk edge.
// Stops at the first mismatch or timeout.
//----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_cpci_core;

   localparam logic [9:0] ctrl_addr   = 10'h100;
   localparam logic [9:0] status_addr = 10'h101;
   localparam logic [9:0] buf_addr    = 10'h110;

   logic        core_clk_int;
   logic        arst_n;
   logic        reg_req;
   logic        reg_rd_wr_l;
   logic [9:0]  reg_addr;
   logic [31:0] reg_wr_data;
   logic        reg_ack;
   logic [31:0] reg_rd_data;
   logic        rp_done;
   logic        rp_init_b;
   logic        rp_cclk;
   logic        rp_en;
   logic        rp_prog_b;
   logic        rp_din;
   logic        disable_reset;

   integer      seed;
   logic [31:0] buf_data [16];
   logic [9:0]  step_addr [$];
   bit          step_rd [$];
   logic [31:0] step_data [$];
   logic [31:0] step_exp [$];

   // Configuration device model state
   int          cclk_cnt;
   bit          init_hold_low;
   int          expected_bits;
   int          bits_seen;
   logic [95:0] shifted;

   cpci_core_top DUT (
      .core_clk_int  (core_clk_int),
      .arst_n        (arst_n),
      .reg_req       (reg_req),
      .reg_rd_wr_l   (reg_rd_wr_l),
      .reg_addr      (reg_addr),
      .reg_wr_data   (reg_wr_data),
      .reg_ack       (reg_ack),
      .reg_rd_data   (reg_rd_data),
      .rp_done       (rp_done),
      .rp_init_b     (rp_init_b),
      .rp_cclk       (rp_cclk),
      .rp_en         (rp_en),
      .rp_prog_b     (rp_prog_b),
      .rp_din        (rp_din),
      .disable_reset (disable_reset)
   );

   always #50 core_clk_int = !core_clk_int;

   // ------------------------------------------------------------------
   // Configuration device model
   // ------------------------------------------------------------------
   always @(posedge core_clk_int) begin
      if (cclk_cnt == 4) begin
         cclk_cnt <= 0;
         rp_cclk  <= !rp_cclk;
         // init_b comes up together with a rising cclk
         if (!rp_cclk && rp_prog_b && !init_hold_low) begin
            rp_init_b <= 1'b1;
         end
      end else begin
         cclk_cnt <= cclk_cnt + 1;
      end
      if (!rp_prog_b) begin
         rp_init_b <= 1'b0;
         rp_done   <= 1'b0;
      end else if (expected_bits > 0 && bits_seen == expected_bits) begin
         rp_done <= 1'b1;
      end
   end

   // Sample din half a core cycle before each rising cclk
   always @(negedge core_clk_int) begin
      if (cclk_cnt == 4 && !rp_cclk && rp_init_b && rp_prog_b && rp_en &&
          bits_seen < expected_bits) begin
         shifted   = {shifted[94:0], rp_din};
         bits_seen = bits_seen + 1;
      end
   end

   // ------------------------------------------------------------------
   // Helpers
   // ------------------------------------------------------------------
   task automatic stop_with_failure(input string reason);
      $display("%s", reason);
      $display("test failed");
      $fatal(1, "simulation stopped on first failure");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("Error: %s is %h, expected %h", name, got, exp);
         stop_with_failure("Value mismatch");
      end
   endtask

   task automatic add_step(input logic [9:0] addr, input bit rd,
                           input logic [31:0] data, input logic [31:0] exp);
      step_addr.push_back(addr);
      step_rd.push_back(rd);
      step_data.push_back(data);
      step_exp.push_back(exp);
   endtask

   // One host access that returns at the negedge where reg_ack is seen
   task automatic reg_access(input logic [9:0] addr, input bit rd,
                             input logic [31:0] data, output logic [31:0] rdata);
      int waited;
      waited = 0;
      @(posedge core_clk_int);
      reg_req     <= 1'b1;
      reg_rd_wr_l <= rd;
      reg_addr    <= addr;
      reg_wr_data <= data;
      @(posedge core_clk_int);
      reg_req <= 1'b0;
      @(negedge core_clk_int);
      while (!reg_ack && waited < 20) begin
         @(negedge core_clk_int);
         waited++;
      end
      if (!reg_ack) begin
         stop_with_failure("Timeout: no reg_ack for a register access");
      end
      rdata = reg_rd_data;
   endtask

   task automatic wait_idle(output logic [31:0] status);
      int polls;
      polls = 0;
      reg_access(status_addr, 1'b1, 32'h0, status);
      while (status[0] && polls < 1000) begin
         reg_access(status_addr, 1'b1, 32'h0, status);
         polls++;
      end
      if (status[0]) begin
         stop_with_failure("Timeout: reprogramming sequencer stayed busy");
      end
   endtask

   // Bound assertion failures end the run right away
   always @(negedge core_clk_int) begin
      if (DUT.u_sva.fail_count != 0) begin
         stop_with_failure("A concurrent assertion on the DUT ports failed");
      end
   end

   // ------------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------------
   initial begin
      logic [31:0] rd;
      int          waited;
      int          low_cycles;

      seed          = 32'ha67c;
      core_clk_int  = 1'b0;
      arst_n        = 1'b0;
      reg_req       = 1'b0;
      reg_rd_wr_l   = 1'b0;
      reg_addr      = '0;
      reg_wr_data   = '0;
      rp_done       = 1'b0;
      rp_init_b     = 1'b0;
      rp_cclk       = 1'b0;
      cclk_cnt      = 0;
      init_hold_low = 1'b0;
      expected_bits = 0;
      bits_seen     = 0;
      shifted       = '0;
      repeat (4) @(posedge core_clk_int);
      arst_n <= 1'b1;

      // Identity words, ignored write, unused regions
      add_step(10'h000, 1'b1, 32'h0, 32'h00000A11);
      add_step(10'h001, 1'b1, 32'h0, 32'h00000002);
      add_step(10'h002, 1'b1, 32'h0, 32'h00000001);
      add_step(10'h003, 1'b1, 32'h0, 32'h00000007);
      add_step(10'h001, 1'b0, 32'hFFFFFFFF, 32'h0);
      add_step(10'h001, 1'b1, 32'h0, 32'h00000002);
      add_step(10'h200, 1'b1, 32'h0, 32'hDEADBEEF);
      add_step(10'h205, 1'b0, 32'h12345678, 32'h0);
      add_step(10'h2FF, 1'b1, 32'h0, 32'hDEADBEEF);
      add_step(10'h310, 1'b0, 32'h0BADF00D, 32'h0);
      add_step(10'h3AB, 1'b1, 32'h0, 32'hDEADBEEF);
      // Buffer fill and read back
      for (int i = 0; i < 16; i++) begin
         buf_data[i] = $random(seed);
         add_step(buf_addr + 10'(i), 1'b0, buf_data[i], 32'h0);
      end
      for (int i = 0; i < 16; i++) begin
         add_step(buf_addr + 10'(i), 1'b1, 32'h0, buf_data[i]);
      end

      for (int i = 0; i < step_addr.size(); i++) begin
         reg_access(step_addr[i], step_rd[i], step_data[i], rd);
         if (step_rd[i]) begin
            check_value("reg_rd_data", rd, step_exp[i]);
         end
      end

      // Full sequence over words 0 to 2
      expected_bits = 96;
      bits_seen     = 0;
      reg_access(ctrl_addr, 1'b0, 32'h00000201, rd);
      waited = 0;
      while (rp_prog_b && waited < 10) begin
         @(negedge core_clk_int);
         waited++;
      end
      if (rp_prog_b) begin
         stop_with_failure("Timeout: rp_prog_b did not go low after start");
      end
      low_cycles = 0;
      while (!rp_prog_b && low_cycles < 20) begin
         check_value("rp_en", rp_en, 32'h1);
         low_cycles++;
         @(negedge core_clk_int);
      end
      check_value("rp_prog_b low cycles", low_cycles, 32'd8);
      wait_idle(rd);
      check_value("status", rd, 32'h0000000A);
      check_value("rp_din bit count", bits_seen, 32'd96);
      check_value("rp_din word 0", shifted[95:64], buf_data[0]);
      check_value("rp_din word 1", shifted[63:32], buf_data[1]);
      check_value("rp_din word 2", shifted[31:0], buf_data[2]);

      // init_b held low by the device
      expected_bits = 0;
      init_hold_low = 1'b1;
      reg_access(ctrl_addr, 1'b0, 32'h00000001, rd);
      wait_idle(rd);
      check_value("status", rd, 32'h00000004);
      check_value("rp_prog_b", rp_prog_b, 32'h1);
      check_value("rp_en", rp_en, 32'h0);
      init_hold_low = 1'b0;

      // hold_reset on and off without a start
      reg_access(ctrl_addr, 1'b0, 32'h00000002, rd);
      check_value("disable_reset", disable_reset, 32'h1);
      reg_access(status_addr, 1'b1, 32'h0, rd);
      check_value("status busy", rd[0], 32'h0);
      check_value("rp_en", rp_en, 32'h0);
      reg_access(ctrl_addr, 1'b0, 32'h00000000, rd);
      check_value("disable_reset", disable_reset, 32'h0);
      reg_access(status_addr, 1'b1, 32'h0, rd);
      check_value("status busy", rd[0], 32'h0);
      check_value("rp_prog_b", rp_prog_b, 32'h1);

      if (DUT.u_sva.fail_count == 0) begin
         $display("test passed");
         $finish;
      end else begin
         stop_with_failure("Concurrent assertions failed during the run");
      end
   end

endmodule

// ==== verification/cpci_core_sva.sv ====
//----------------------------------------------------------------------
// Concurrent checks on the top-level ports, bound to cpci_core_top.
// fail_count is read by the testbench at the end of the run.
//----------------------------------------------------------------------
`timescale 1ns/1ps

module cpci_core_sva (
   input logic core_clk_int,
   input logic arst_n,
   input logic reg_req,
   input logic reg_ack,
   input logic rp_prog_b,
   input logic rp_en
);

   int fail_count = 0;

   // Ack is one cycle wide
   ack_pulse: assert property (@(posedge core_clk_int) disable iff (!arst_n)
      reg_ack |=> !reg_ack)
      else begin
         $error("reg_ack held high for more than one cycle");
         fail_count++;
      end

   ack_latency: assert property (@(posedge core_clk_int) disable iff (!arst_n)
      reg_req |-> ##2 reg_ack)
      else begin
         $error("reg_ack did not follow reg_req by 2 cycles");
         fail_count++;
      end

   // Device enable covers the whole prog_b pulse
   prog_b_en: assert property (@(posedge core_clk_int) disable iff (!arst_n)
      !rp_prog_b |-> rp_en)
      else begin
         $error("rp_prog_b low while rp_en low");
         fail_count++;
      end

endmodule

bind cpci_core_top cpci_core_sva u_sva (
   .core_clk_int (core_clk_int),
   .arst_n       (arst_n),
   .reg_req      (reg_req),
   .reg_ack      (reg_ack),
   .rp_prog_b    (rp_prog_b),
   .rp_en        (rp_en)
);

// ==== hw/cpci_core_top.sv ====
//----------------------------------------------------------------------
// Register side of the board core on core_clk_int.
// Host keeps reg_req low until it has seen reg_ack.
//----------------------------------------------------------------------
`timescale 1ns/1ps

module cpci_core_top (
   input  logic                                     core_clk_int,
   input  logic                                     arst_n,

   // Host register bus
   input  logic                                     reg_req,
   input  logic                                     reg_rd_wr_l,
   input  logic [core_regs_pkg::reg_addr_width-1:0] reg_addr,
   input  logic [core_regs_pkg::reg_data_width-1:0] reg_wr_data,
   output logic                                     reg_ack,
   output logic [core_regs_pkg::reg_data_width-1:0] reg_rd_data,

   // Configuration device pins
   input  logic                                     rp_done,
   input  logic                                     rp_init_b,
   input  logic                                     rp_cclk,
   output logic                                     rp_en,
   output logic                                     rp_prog_b,
   output logic                                     rp_din,
   output logic                                     disable_reset
);

   reg_bus_if id_bus ();
   reg_bus_if reprog_bus ();

   reg_decoder u_reg_decoder (
      .core_clk_int (core_clk_int),
      .arst_n       (arst_n),
      .reg_req      (reg_req),
      .reg_rd_wr_l  (reg_rd_wr_l),
      .reg_addr     (reg_addr),
      .reg_wr_data  (reg_wr_data),
      .reg_ack      (reg_ack),
      .reg_rd_data  (reg_rd_data),
      .id_bus       (id_bus.initiator),
      .reprog_bus   (reprog_bus.initiator)
   );

   // Region 0
   device_id_regs u_device_id_regs (
      .core_clk_int (core_clk_int),
      .arst_n       (arst_n),
      .bus          (id_bus.target)
   );

   // Region 1
   reprog_ctrl u_reprog_ctrl (
      .core_clk_int  (core_clk_int),
      .arst_n        (arst_n),
      .bus           (reprog_bus.target),
      .rp_done       (rp_done),
      .rp_init_b     (rp_init_b),
      .rp_cclk       (rp_cclk),
      .rp_en         (rp_en),
      .rp_prog_b     (rp_prog_b),
      .rp_din        (rp_din),
      .disable_reset (disable_reset)
   );

endmodule

// ==== hw/reprog_ctrl.sv ====
//----------------------------------------------------------------------
// Bitstream buffer, control and status words, and the sequencer FSM.
// The device must hold init_b and done low while prog_b is low.
// rp_cclk must stay slow enough to be seen through the synchronizer.
//----------------------------------------------------------------------
`timescale 1ns/1ps

module reprog_ctrl (
   input  logic      core_clk_int,
   input  logic      arst_n,
   reg_bus_if.target bus,
   input  logic      rp_done,
   input  logic      rp_init_b,
   input  logic      rp_cclk,
   output logic      rp_en,
   output logic      rp_prog_b,
   output logic      rp_din,
   output logic      disable_reset
);
   import core_regs_pkg::*;

   logic [reg_data_width-1:0]   buf_mem [buf_words];
   reg_word_u                   wr_word;
   reg_word_u                   ctrl_word;
   logic [reg_data_width-1:0]   status_word;
   logic [reg_offset_width-1:0] buf_rel;
   logic [buf_idx_width-1:0]    buf_idx;
   logic                        in_buf;
   logic                        wr_req;
   logic                        ctrl_wr;
   logic                        buf_wr;
   logic                        busy;

   logic                        start_q;
   logic                        hold_reset_q;
   logic [buf_idx_width-1:0]    last_word_q;
   logic                        done_seen_q;
   logic                        init_timeout_q;

   logic [2:0]                  sync_meta;
   logic [2:0]                  sync_q;
   logic                        cclk_prev;
   logic                        cclk_rise;
   logic                        init_b_s;
   logic                        done_s;

   logic [state_width-1:0]      state;
   logic [cnt_width-1:0]        cnt;
   logic [buf_idx_width-1:0]    word_idx;
   logic [bit_idx_width-1:0]    bit_idx;
   logic [reg_data_width-1:0]   cur_word;

   // ------------------------------------------------------------------
   // Register access
   // ------------------------------------------------------------------
   assign wr_word.raw = bus.wr_data;
   assign wr_req      = bus.req && !bus.rd_wr_l;
   assign buf_rel     = bus.offset - buf_base;
   assign buf_idx     = buf_rel[buf_idx_width-1:0];
   assign in_buf      = (bus.offset >= buf_base) && (bus.offset < buf_base + buf_words);

   // Pending start counts as busy
   assign busy    = (state != st_idle) || start_q;
   assign ctrl_wr = wr_req && (bus.offset == ctrl_offset) && !busy;
   assign buf_wr  = wr_req && in_buf && !busy;

   always_comb begin
      ctrl_word.raw                    = '0;
      ctrl_word.ctrl_fields.hold_reset = hold_reset_q;
      ctrl_word.ctrl_fields.last_word  = last_word_q;
   end

   assign status_word = {{(reg_data_width-4){1'b0}}, init_b_s, init_timeout_q,
                          done_seen_q, busy};

   always_ff @(posedge core_clk_int or negedge arst_n) begin
      if (!arst_n) begin
         bus.ack      <= 1'b0;
         start_q      <= 1'b0;
         hold_reset_q <= 1'b0;
         last_word_q  <= '0;
      end else begin
         bus.ack <= bus.req;
         // Sequence starts the cycle after the ack
         start_q <= ctrl_wr && wr_word.ctrl_fields.start;
         if (ctrl_wr) begin
            hold_reset_q <= wr_word.ctrl_fields.hold_reset;
            last_word_q  <= wr_word.ctrl_fields.last_word;
         end
      end
   end

   always_ff @(posedge core_clk_int) begin
      if (bus.req && bus.rd_wr_l) begin
         if (in_buf) begin
            bus.rd_data <= buf_mem[buf_idx];
         end else if (bus.offset == ctrl_offset) begin
            bus.rd_data <= ctrl_word.raw;
         end else if (bus.offset == status_offset) begin
            bus.rd_data <= status_word;
         end else begin
            bus.rd_data <= '0;
         end
      end
      if (buf_wr) begin
         buf_mem[buf_idx] <= wr_word.raw;
      end
   end

   // ------------------------------------------------------------------
   // Input synchronizers and cclk edge detect
   // ------------------------------------------------------------------
   always_ff @(posedge core_clk_int or negedge arst_n) begin
      if (!arst_n) begin
         sync_meta <= '0;
         sync_q    <= '0;
         cclk_prev <= 1'b0;
      end else begin
         sync_meta <= {rp_cclk, rp_init_b, rp_done};
         sync_q    <= sync_meta;
         cclk_prev <= sync_q[2];
      end
   end

   assign cclk_rise = sync_q[2] && !cclk_prev;
   assign init_b_s  = sync_q[1];
   assign done_s    = sync_q[0];

   // ------------------------------------------------------------------
   // Sequencer
   // ------------------------------------------------------------------
   always_ff @(posedge core_clk_int or negedge arst_n) begin
      if (!arst_n) begin
         state          <= st_idle;
         cnt            <= '0;
         word_idx       <= '0;
         bit_idx        <= '1;
         done_seen_q    <= 1'b0;
         init_timeout_q <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               if (start_q) begin
                  state          <= st_prog_low;
                  cnt            <= '0;
                  done_seen_q    <= 1'b0;
                  init_timeout_q <= 1'b0;
               end
            end
            st_prog_low: begin
               if (cnt == cnt_width'(prog_low_cycles - 1)) begin
                  state <= st_wait_init;
                  cnt   <= '0;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            st_wait_init: begin
               if (init_b_s) begin
                  state    <= st_shift;
                  word_idx <= '0;
                  bit_idx  <= '1;
               end else if (cnt == cnt_width'(init_timeout_cycles - 1)) begin
                  state          <= st_idle;
                  init_timeout_q <= 1'b1;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            st_shift: begin
               // MSB first, the index wrapping to the top bit of the next word
               if (cclk_rise) begin
                  bit_idx <= bit_idx - 1'b1;
                  if (bit_idx == '0) begin
                     if (word_idx == last_word_q) begin
                        state <= st_wait_done;
                     end else begin
                        word_idx <= word_idx + 1'b1;
                     end
                  end
               end
            end
            st_wait_done: begin
               if (done_s) begin
                  state       <= st_idle;
                  done_seen_q <= 1'b1;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   assign cur_word      = buf_mem[word_idx];
   assign rp_din        = (state == st_shift) && cur_word[bit_idx];
   assign rp_en         = (state != st_idle);
   assign rp_prog_b     = (state != st_prog_low);
   assign disable_reset = hold_reset_q;

endmodule

// ==== hw/device_id_regs.sv ====
//----------------------------------------------------------------------
// Read-only identification words at offsets 0 to 3.
// Writes are acknowledged and dropped; other offsets read as zero.
//----------------------------------------------------------------------
`timescale 1ns/1ps

module device_id_regs (
   input  logic      core_clk_int,
   input  logic      arst_n,
   reg_bus_if.target bus
);
   import core_regs_pkg::*;

   logic [reg_data_width-1:0] id_word;

   // Constant lookup by offset
   always_comb begin
      case (bus.offset)
         8'd0:    id_word = device_id;
         8'd1:    id_word = device_major;
         8'd2:    id_word = device_minor;
         8'd3:    id_word = device_revision;
         default: id_word = '0;
      endcase
   end

   // Ack one cycle after req
   always_ff @(posedge core_clk_int or negedge arst_n) begin
      if (!arst_n) begin
         bus.ack <= 1'b0;
      end else begin
         bus.ack <= bus.req;
      end
   end

   // Read data only loads on reads
   always_ff @(posedge core_clk_int) begin
      if (bus.req && bus.rd_wr_l) begin
         bus.rd_data <= id_word;
      end
   end

endmodule

// ==== hw/reg_decoder.sv ====
//----------------------------------------------------------------------
// Four-region address decoder. Only one request may be outstanding.
// reg_ack follows reg_req by exactly 2 cycles in every region.
//----------------------------------------------------------------------
`timescale 1ns/1ps

module reg_decoder (
   input  logic                                      core_clk_int,
   input  logic                                      arst_n,
   input  logic                                      reg_req,
   input  logic                                      reg_rd_wr_l,
   input  logic [core_regs_pkg::reg_addr_width-1:0]  reg_addr,
   input  logic [core_regs_pkg::reg_data_width-1:0]  reg_wr_data,
   output logic                                      reg_ack,
   output logic [core_regs_pkg::reg_data_width-1:0]  reg_rd_data,
   reg_bus_if.initiator                              id_bus,
   reg_bus_if.initiator                              reprog_bus
);
   import core_regs_pkg::*;

   logic                        req_q;
   logic [region_width-1:0]     region_q;
   logic                        rd_wr_l_q;
   logic [reg_offset_width-1:0] offset_q;
   logic [reg_data_width-1:0]   wr_data_q;
   logic                        unused_ack_q;
   logic                        region_unused;

   // ------------------------------------------------------------------
   // Request capture, cycle 1
   // ------------------------------------------------------------------
   always_ff @(posedge core_clk_int or negedge arst_n) begin
      if (!arst_n) begin
         req_q    <= 1'b0;
         region_q <= region_id;
      end else begin
         req_q <= reg_req;
         if (reg_req) begin
            region_q <= reg_addr[reg_addr_width-1:reg_offset_width];
         end
      end
   end

   always_ff @(posedge core_clk_int) begin
      if (reg_req) begin
         rd_wr_l_q <= reg_rd_wr_l;
         offset_q  <= reg_addr[reg_offset_width-1:0];
         wr_data_q <= reg_wr_data;
      end
   end

   assign region_unused = (region_q != region_id) && (region_q != region_reprog);

   // Answer for regions 2 and 3 lines up with a block ack
   always_ff @(posedge core_clk_int or negedge arst_n) begin
      if (!arst_n) begin
         unused_ack_q <= 1'b0;
      end else begin
         unused_ack_q <= req_q && region_unused;
      end
   end

   // Forward to the blocks
   assign id_bus.req         = req_q && (region_q == region_id);
   assign id_bus.rd_wr_l     = rd_wr_l_q;
   assign id_bus.offset      = offset_q;
   assign id_bus.wr_data     = wr_data_q;

   assign reprog_bus.req     = req_q && (region_q == region_reprog);
   assign reprog_bus.rd_wr_l = rd_wr_l_q;
   assign reprog_bus.offset  = offset_q;
   assign reprog_bus.wr_data = wr_data_q;

   // ------------------------------------------------------------------
   // Response merge, cycle 2
   // ------------------------------------------------------------------
   always_comb begin
      case (region_q)
         region_id: begin
            reg_ack     = id_bus.ack;
            reg_rd_data = id_bus.rd_data;
         end
         region_reprog: begin
            reg_ack     = reprog_bus.ack;
            reg_rd_data = reprog_bus.rd_data;
         end
         default: begin
            reg_ack     = unused_ack_q;
            reg_rd_data = unused_read_value;
         end
      endcase
   end

endmodule

// ==== hw/reg_bus_if.sv ====
//----------------------------------------------------------------------
// Register bus from the decoder to one block.
// One request at a time and ack one cycle after req.
//----------------------------------------------------------------------
`timescale 1ns/1ps

interface reg_bus_if;
   import core_regs_pkg::*;

   logic                        req;
   logic                        rd_wr_l;
   logic [reg_offset_width-1:0] offset;
   logic [reg_data_width-1:0]   wr_data;
   logic                        ack;
   logic [reg_data_width-1:0]   rd_data;

   // Decoder side
   modport initiator (
      output req, rd_wr_l, offset, wr_data,
      input  ack, rd_data
   );

   // Register block side
   modport target (
      input  req, rd_wr_l, offset, wr_data,
      output ack, rd_data
   );

endinterface

// ==== hw/core_regs_pkg.sv ====
//----------------------------------------------------------------------
// Address map, widths and constants shared by the register blocks.
// Host word address is 10 bits: region in bits 9:8, offset in 7:0.
// Buffer offsets assume buf_base is a multiple of buf_words.
//----------------------------------------------------------------------
package core_regs_pkg;

   // Bus widths
   localparam int reg_addr_width   = 10;
   localparam int reg_data_width   = 32;
   localparam int reg_offset_width = 8;
   localparam int region_width     = reg_addr_width - reg_offset_width;

   // Region numbers. Regions 2 and 3 are unused
   localparam logic [region_width-1:0] region_id     = 2'd0;
   localparam logic [region_width-1:0] region_reprog = 2'd1;

   localparam logic [reg_data_width-1:0] unused_read_value = 32'hDEADBEEF;

   // Identity words at offsets 0 to 3 of the ID region
   localparam logic [reg_data_width-1:0] device_id       = 32'h00000A11;
   localparam logic [reg_data_width-1:0] device_major    = 32'h00000002;
   localparam logic [reg_data_width-1:0] device_minor    = 32'h00000001;
   localparam logic [reg_data_width-1:0] device_revision = 32'h00000007;

   // ------------------------------------------------------------------
   // Reprogramming region
   // ------------------------------------------------------------------
   localparam int buf_words     = 16;
   localparam int buf_idx_width = $clog2(buf_words);
   localparam int bit_idx_width = $clog2(reg_data_width);

   localparam logic [reg_offset_width-1:0] buf_base      = 8'd16;
   localparam logic [reg_offset_width-1:0] ctrl_offset   = 8'd0;
   localparam logic [reg_offset_width-1:0] status_offset = 8'd1;

   // Sequencer timing in core cycles
   localparam int prog_low_cycles     = 8;
   localparam int init_timeout_cycles = 64;
   localparam int cnt_width           = $clog2(init_timeout_cycles);

   // Sequencer state codes
   localparam int state_width = 3;
   localparam logic [state_width-1:0] st_idle      = 3'd0;
   localparam logic [state_width-1:0] st_prog_low  = 3'd1;
   localparam logic [state_width-1:0] st_wait_init = 3'd2;
   localparam logic [state_width-1:0] st_shift     = 3'd3;
   localparam logic [state_width-1:0] st_wait_done = 3'd4;

   // Control word fields
   typedef struct packed {
      logic [19:0]              rsvd_hi;
      logic [buf_idx_width-1:0] last_word;
      logic [5:0]               rsvd_lo;
      logic                     hold_reset;
      logic                     start;
   } ctrl_fields_t;

   // Same register word seen raw or as control fields
   typedef union packed {
      logic [reg_data_width-1:0] raw;
      ctrl_fields_t              ctrl_fields;
   } reg_word_u;

endpackage
